/* rtl/pelletPkg.sv */
`default_nettype none

package pelletPkg;

    localparam int NumPellets = 16;
    // pellets below this index make the player grow
    localparam int GrowPellets = 8;

    typedef logic [9:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    typedef point_t [NumPellets-1:0] pelletSet_t;
    typedef logic [NumPellets-1:0] pelletMask_t;
    typedef logic [3:0] size_t;

    // outcome of one frame's collision check
    typedef enum logic [1:0] {
        HIT_NONE   = 2'd0,
        HIT_GROW   = 2'd1,
        HIT_SHRINK = 2'd2
    } hitKind_t;

    // spawn spots after reset
    localparam pelletSet_t PelletHome = '{
        0:  '{x: 10'd150, y: 10'd300},
        1:  '{x: 10'd12,  y: 10'd7},
        2:  '{x: 10'd17,  y: 10'd58},
        3:  '{x: 10'd45,  y: 10'd69},
        4:  '{x: 10'd66,  y: 10'd88},
        5:  '{x: 10'd77,  y: 10'd92},
        6:  '{x: 10'd89,  y: 10'd120},
        7:  '{x: 10'd100, y: 10'd130},
        8:  '{x: 10'd200, y: 10'd66},
        9:  '{x: 10'd300, y: 10'd99},
        10: '{x: 10'd400, y: 10'd89},
        11: '{x: 10'd455, y: 10'd300},
        12: '{x: 10'd543, y: 10'd400},
        13: '{x: 10'd602, y: 10'd38},
        14: '{x: 10'd625, y: 10'd5},
        15: '{x: 10'd644, y: 10'd79}
    };

endpackage

`default_nettype wire

/* rtl/frameSizeTracker.sv */
`default_nettype none

module frameSizeTracker
    import pelletPkg::*;
#(
    parameter int MinSize   = 1,
    parameter int MaxSize   = 10,
    parameter int StartSize = 4
)
(
    input  wire           Clk,
    input  wire           rst,
    input  wire           frameClk,
    input  wire hitKind_t hitKind,
    output logic          frameTick,
    output size_t         playerSize,
    output logic [31:0]   score
);

    logic frameClkDelayed;

    always_ff @(posedge Clk)
    begin
        if (rst)
            frameClkDelayed <= 1'b0;
        else
            frameClkDelayed <= frameClk;
    end

    // one cycle pulse on the rise of the frame level
    assign frameTick = frameClk && !frameClkDelayed;

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            score      <= '0;
            playerSize <= size_t'(StartSize);
        end
        else if (frameTick && (hitKind != HIT_NONE))
        begin
            score <= score + 32'd1;
            // step the size, saturating at both ends
            case (hitKind)
                HIT_GROW:
                    if (playerSize < size_t'(MaxSize))
                        playerSize <= playerSize + size_t'(1);
                HIT_SHRINK:
                    if (playerSize > size_t'(MinSize))
                        playerSize <= playerSize - size_t'(1);
                default:
                    playerSize <= playerSize;
            endcase
        end
    end

    // size never leaves its legal range
    sizeInRange: assert property (@(posedge Clk) disable iff (rst)
        (playerSize >= size_t'(MinSize)) && (playerSize <= size_t'(MaxSize)));

endmodule

`default_nettype wire

/* rtl/collisionDetector.sv */
`default_nettype none

module collisionDetector
    import pelletPkg::*;
#(
    parameter int PelletRadius = 4
)
(
    input  wire pelletSet_t pellets,
    input  wire point_t     playerPos,
    input  wire size_t      playerSize,
    output pelletMask_t     touched,
    output hitKind_t        hitKind
);

    logic [21:0] reach;
    logic [21:0] reachSq;
    logic        growHit;
    logic        shrinkHit;

    // pellet radius plus player radius
    assign reach   = 22'(PelletRadius) + 22'(playerSize);
    assign reachSq = reach * reach;

    for (genvar i = 0; i < NumPellets; i++)
    begin : gPellet
        logic signed [10:0] dx;
        logic signed [10:0] dy;
        logic signed [21:0] distSq;

        // signed so that a pellet left of or above the player still counts
        assign dx = $signed({1'b0, playerPos.x}) - $signed({1'b0, pellets[i].x});
        assign dy = $signed({1'b0, playerPos.y}) - $signed({1'b0, pellets[i].y});

        // at most 2 * 1023^2, fits in 21 bits
        assign distSq = dx * dx + dy * dy;

        assign touched[i] = $unsigned(distSq) <= reachSq;
    end

    // split the mask into the two pellet kinds
    assign growHit   = |touched[GrowPellets-1:0];
    assign shrinkHit = |touched[NumPellets-1:GrowPellets];

    // grow wins when both kinds are touched in one frame
    always_comb
    begin
        if (growHit)
            hitKind = HIT_GROW;
        else if (shrinkHit)
            hitKind = HIT_SHRINK;
        else
            hitKind = HIT_NONE;
    end

endmodule

`default_nettype wire

/* rtl/pelletStore.sv */
`default_nettype none

module pelletStore
    import pelletPkg::*;
(
    input  wire              Clk,
    input  wire              rst,
    input  wire              frameTick,
    input  wire pelletMask_t touched,
    input  wire point_t      randomPos,
    output pelletSet_t       pellets
);

    point_t respawnPos;

    // respawns land in the upper left 512 by 256 area
    assign respawnPos = '{
        x: {1'b0, randomPos.x[8:0]},
        y: {2'b00, randomPos.y[7:0]}
    };

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            pellets <= PelletHome;
        end
        else if (frameTick)
        begin
            // every touched pellet takes the same new spot
            for (int i = 0; i < NumPellets; i++)
            begin
                if (touched[i])
                    pellets[i] <= respawnPos;
            end
        end
    end

    for (genvar i = 0; i < NumPellets; i++)
    begin : gCheck
        // a respawned pellet stays inside the masked area
        respawnInArea: assert property (@(posedge Clk) disable iff (rst)
            (frameTick && touched[i]) |=> (pellets[i].y < 10'd256));
    end

endmodule

`default_nettype wire

/* rtl/pixelMatcher.sv */
`default_nettype none

module pixelMatcher
    import pelletPkg::*;
#(
    parameter int PelletRadius = 4
)
(
    input  wire pelletSet_t pellets,
    input  wire point_t     drawPos,
    output pelletMask_t     pelletHit
);

    localparam logic [21:0] RadiusSq = 22'(PelletRadius * PelletRadius);

    for (genvar i = 0; i < NumPellets; i++)
    begin : gPellet
        logic signed [10:0] dx;
        logic signed [10:0] dy;
        logic signed [21:0] distSq;

        assign dx = $signed({1'b0, drawPos.x}) - $signed({1'b0, pellets[i].x});
        assign dy = $signed({1'b0, drawPos.y}) - $signed({1'b0, pellets[i].y});
        assign distSq = dx * dx + dy * dy;

        // pixel lies on the disc of this pellet
        assign pelletHit[i] = $unsigned(distSq) <= RadiusSq;
    end

endmodule

`default_nettype wire

/* rtl/pelletField.sv */
`default_nettype none

module pelletField
    import pelletPkg::*;
#(
    parameter int PelletRadius = 4,
    parameter int MinSize      = 1,
    parameter int MaxSize      = 10,
    parameter int StartSize    = 4
)
(
    input  wire          Clk,
    input  wire          rst,
    input  wire          frameClk,
    input  wire point_t  playerPos,
    input  wire point_t  randomPos,
    input  wire point_t  drawPos,
    output pelletMask_t  pelletHit,
    output logic         collisionGrow,
    output logic         collisionShrink,
    output size_t        playerSize,
    output logic [31:0]  score
);

    pelletSet_t  pellets;
    pelletMask_t touched;
    hitKind_t    hitKind;
    logic        frameTick;

    frameSizeTracker #(
        .MinSize   (MinSize),
        .MaxSize   (MaxSize),
        .StartSize (StartSize)
    ) tracker0 (
        .Clk        (Clk),
        .rst        (rst),
        .frameClk   (frameClk),
        .hitKind    (hitKind),
        .frameTick  (frameTick),
        .playerSize (playerSize),
        .score      (score)
    );

    collisionDetector #(
        .PelletRadius (PelletRadius)
    ) detector0 (
        .pellets    (pellets),
        .playerPos  (playerPos),
        .playerSize (playerSize),
        .touched    (touched),
        .hitKind    (hitKind)
    );

    pelletStore store0 (
        .Clk       (Clk),
        .rst       (rst),
        .frameTick (frameTick),
        .touched   (touched),
        .randomPos (randomPos),
        .pellets   (pellets)
    );

    pixelMatcher #(
        .PelletRadius (PelletRadius)
    ) matcher0 (
        .pellets   (pellets),
        .drawPos   (drawPos),
        .pelletHit (pelletHit)
    );

    // hit kind decoded into the two flags, at most one is set
    assign collisionGrow   = (hitKind == HIT_GROW);
    assign collisionShrink = (hitKind == HIT_SHRINK);

endmodule

`default_nettype wire

/* dv/pelletFieldChecker.sv */
`default_nettype none

module pelletFieldChecker
    import pelletPkg::*;
(
    input  wire              Clk,
    input  wire              rst,
    input  wire              frameClk,
    input  wire point_t      playerPos,
    input  wire point_t      randomPos,
    input  wire point_t      drawPos,
    input  wire pelletMask_t pelletHit,
    input  wire              collisionGrow,
    input  wire              collisionShrink,
    input  wire size_t       playerSize,
    input  wire [31:0]       score,
    input  wire [127:0]      testName,
    output int               errorCount
);

    localparam int Radius    = 4;
    localparam int MinSize   = 1;
    localparam int MaxSize   = 10;
    localparam int StartSize = 4;

    // reset spots of the sixteen pellets
    int homeX [16] = '{150, 12, 17, 45, 66, 77, 89, 100, 200, 300, 400, 455, 543, 602, 625, 644};
    int homeY [16] = '{300, 7, 58, 69, 88, 92, 120, 130, 66, 99, 89, 300, 400, 38, 5, 79};

    int   modelX [16];
    int   modelY [16];
    int   modelSize;
    int   modelScore;
    logic modelFrameDelayed;

    initial errorCount = 0;

    function automatic bit covers(input int ax, input int ay, input int bx, input int by,
                                  input int radius);
        int dx;
        int dy;
        dx = ax - bx;
        dy = ay - by;
        return (dx * dx + dy * dy) <= (radius * radius);
    endfunction

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual)
        begin
            errorCount++;
            $display("CHECK FAILED %0s %0s: expected %0h, actual %0h",
                     testName, what, expected, actual);
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge Clk)
    begin : checkCycle
        bit          tick;
        bit          growHit;
        bit          shrinkHit;
        logic [15:0] expHit;
        logic [15:0] eaten;
        if (rst)
        begin
            for (int i = 0; i < 16; i++)
            begin
                modelX[i] = homeX[i];
                modelY[i] = homeY[i];
            end
            modelSize         = StartSize;
            modelScore        = 0;
            modelFrameDelayed = 1'b0;
        end
        else
        begin
            tick      = frameClk && !modelFrameDelayed;
            growHit   = 1'b0;
            shrinkHit = 1'b0;
            for (int i = 0; i < 16; i++)
            begin
                eaten[i]  = covers(playerPos.x, playerPos.y, modelX[i], modelY[i],
                                   Radius + modelSize);
                expHit[i] = covers(drawPos.x, drawPos.y, modelX[i], modelY[i], Radius);
                if (eaten[i] && i < 8)
                    growHit = 1'b1;
                else if (eaten[i])
                    shrinkHit = 1'b1;
            end
            compare("score", modelScore, score);
            compare("playerSize", modelSize, playerSize);
            compare("pelletHit", expHit, pelletHit);
            compare("collisionGrow", growHit, collisionGrow);
            compare("collisionShrink", !growHit && shrinkHit, collisionShrink);
            // state seen by the DUT on the next rising edge
            if (tick && (growHit || shrinkHit))
            begin
                modelScore++;
                if (growHit && modelSize < MaxSize)
                    modelSize++;
                else if (!growHit && modelSize > MinSize)
                    modelSize--;
            end
            for (int i = 0; i < 16; i++)
            begin
                if (tick && eaten[i])
                begin
                    modelX[i] = randomPos.x & 10'h1FF;
                    modelY[i] = randomPos.y & 10'h0FF;
                end
            end
            modelFrameDelayed = frameClk;
        end
    end

endmodule

`default_nettype wire

/* dv/pelletFieldTb.sv */
`default_nettype none

module pelletFieldTb
    import pelletPkg::*;
();

    localparam int Seed        = 7027;
    localparam int ResetCycles = 10;
    localparam int Margin      = 50;

    typedef struct packed {
        logic [127:0] name;
        point_t       playerPos;
        point_t       randomPos;
        point_t       drawPos;
        logic         pulse;
    } row_t;

    row_t        stimulus [$];
    logic        Clk;
    logic        rst;
    logic        frameClk;
    point_t      playerPos;
    point_t      randomPos;
    point_t      drawPos;
    pelletMask_t pelletHit;
    logic        collisionGrow;
    logic        collisionShrink;
    size_t       playerSize;
    logic [31:0] score;
    logic [127:0] testName;
    int          errorCount;
    int          cycleCount;
    int          timeoutLimit;

    pelletField dut0 (
        .Clk             (Clk),
        .rst             (rst),
        .frameClk        (frameClk),
        .playerPos       (playerPos),
        .randomPos       (randomPos),
        .drawPos         (drawPos),
        .pelletHit       (pelletHit),
        .collisionGrow   (collisionGrow),
        .collisionShrink (collisionShrink),
        .playerSize      (playerSize),
        .score           (score)
    );

    pelletFieldChecker checker0 (
        .Clk             (Clk),
        .rst             (rst),
        .frameClk        (frameClk),
        .playerPos       (playerPos),
        .randomPos       (randomPos),
        .drawPos         (drawPos),
        .pelletHit       (pelletHit),
        .collisionGrow   (collisionGrow),
        .collisionShrink (collisionShrink),
        .playerSize      (playerSize),
        .score           (score),
        .testName        (testName),
        .errorCount      (errorCount)
    );

    initial
    begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    function automatic point_t pt(input int x, input int y);
        return '{x: coord_t'(x), y: coord_t'(y)};
    endfunction

    function automatic point_t randomPoint();
        return pt($urandom % 1024, $urandom % 1024);
    endfunction

    task automatic addRow(input logic [127:0] name, input point_t player, input point_t rnd,
                          input point_t draw, input logic pulse);
        stimulus.push_back('{name: name, playerPos: player, randomPos: rnd,
                             drawPos: draw, pulse: pulse});
    endtask

    task automatic buildTable();
        point_t spot;
        // far corner, away from every pellet
        addRow("reset_home3", pt(1000, 1000), randomPoint(), pt(45, 69), 1'b0);
        addRow("reset_home12", pt(1000, 1000), randomPoint(), pt(543, 400), 1'b0);
        // upper bits of randomPos must be masked away
        addRow("grow_hit", pt(45, 69), pt(812, 456), pt(300, 200), 1'b1);
        addRow("grow_probe", pt(1000, 1000), randomPoint(), pt(300, 200), 1'b0);
        addRow("shrink_hit", pt(543, 400), pt(817, 456), pt(305, 200), 1'b1);
        // pellet respawns under the player, so every frame is a hit
        for (int i = 0; i < 8; i++)
            addRow("grow_sat", pt(100, 130), pt(100, 130), pt(100, 130), 1'b1);
        for (int i = 0; i < 11; i++)
            addRow("shrink_sat", pt(602, 38), pt(602, 38), pt(602, 38), 1'b1);
        for (int i = 0; i < 2; i++)
            addRow("miss", pt(1000, 1000), randomPoint(), randomPoint(), 1'b1);
        // touches grow pellet 3 and shrink pellet 12 together
        spot = randomPoint();
        addRow("grow_priority", pt(302, 200), spot, pt(302, 200), 1'b1);
        addRow("priority_probe", pt(1000, 1000), randomPoint(),
               pt(spot.x & 10'h1FF, spot.y & 10'h0FF), 1'b0);
    endtask

    // frame level high for two cycles, then low for two
    task automatic applyRow(input row_t row);
        @(posedge Clk);
        testName  <= row.name;
        playerPos <= row.playerPos;
        randomPos <= row.randomPos;
        drawPos   <= row.drawPos;
        frameClk  <= row.pulse;
        @(posedge Clk);
        @(posedge Clk);
        frameClk <= 1'b0;
        @(posedge Clk);
    endtask

    always @(posedge Clk)
    begin
        cycleCount++;
        if (cycleCount >= timeoutLimit)
        begin
            $display("Timeout: stimulus still running after %0d cycles", cycleCount);
            $display("Simulation failed");
            $finish;
        end
    end

    initial
    begin
        void'($urandom(Seed));
        cycleCount   = 0;
        rst          = 1'b1;
        frameClk     = 1'b0;
        playerPos    = pt(1000, 1000);
        randomPos    = pt(0, 0);
        drawPos      = pt(1000, 1000);
        testName     = "reset";
        buildTable();
        timeoutLimit = stimulus.size() * 4 + Margin;
        repeat (ResetCycles) @(posedge Clk);
        rst <= 1'b0;
        foreach (stimulus[i])
            applyRow(stimulus[i]);
        // let the checker see the last cycle
        @(negedge Clk);
        @(posedge Clk);
        $display("Rows applied: %0d, errors: %0d", stimulus.size(), errorCount);
        if (errorCount == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
rtl/pelletPkg.sv
rtl/frameSizeTracker.sv
rtl/collisionDetector.sv
rtl/pelletStore.sv
rtl/pixelMatcher.sv
rtl/pelletField.sv
dv/pelletFieldChecker.sv
dv/pelletFieldTb.sv
